/* hw/mod_sq_pkg.sv */
package mod_sq_pkg;

   // word geometry of the redundant operand
   localparam int word_len     = 16;   // radix of one word
   localparam int bit_len      = 17;   // stored element, one spare bit for carries
   localparam int num_words    = 4;    // nonredundant words, 64-bit modulus
   localparam int num_elements = 6;    // plus two redundant words

   // squaring grid
   localparam int grid_cols    = 2 * num_elements;
   localparam int col_len      = 29;   // 19b product slice plus growth of the column sum
   localparam int acc_len      = 29;

   // reduction tables
   localparam int lut_addr_len = 9;    // lsb pass uses [7:0], msb pass uses [16:8]
   localparam int lut_cols     = grid_cols - num_words;  // columns 4..11

   typedef logic [bit_len-1:0] element_t;

   // input, output and loopback value, element k weighs 2^(16k)
   typedef element_t [num_elements-1:0] operand_t;

   // carry-save form of every grid column
   typedef struct packed {
      logic [grid_cols-1:0][col_len-1:0] carry;
      logic [grid_cols-1:0][col_len-1:0] sum;
   } grid_cv_t;

   // square after the neighbour carries are folded in
   typedef element_t [grid_cols-1:0] grid_red_t;

   typedef enum logic [1:0] {
      idle,
      phase_0,     // tables addressed with msb fields
      phase_1,     // lsb fields, msb rows come back
      phase_2      // lsb rows come back, result is registered
   } phase_e;

   // one table lookup spread over the result words
   typedef element_t [num_elements-1:0] table_row_t;

endpackage

/* hw/square_sequencer.sv */
`timescale 1ns/100ps

module square_sequencer (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  mod_sq_pkg::operand_t sq_in,
   input  mod_sq_pkg::operand_t sq_out,
   output mod_sq_pkg::phase_e   phase,
   output mod_sq_pkg::operand_t operand,
   output logic                 valid
);

   mod_sq_pkg::phase_e   next_phase;
   mod_sq_pkg::operand_t sq_in_q;     // captured start operand
   logic                 load;        // first iteration squares sq_in_q
   logic                 take_start;

   // start only counts while nothing is running
   assign take_start = start && (phase == mod_sq_pkg::idle);

   always_comb begin
      next_phase = mod_sq_pkg::idle;
      unique case (phase)
         mod_sq_pkg::idle:    next_phase = take_start ? mod_sq_pkg::phase_0 : mod_sq_pkg::idle;
         mod_sq_pkg::phase_0: next_phase = mod_sq_pkg::phase_1;
         mod_sq_pkg::phase_1: next_phase = mod_sq_pkg::phase_2;
         mod_sq_pkg::phase_2: next_phase = mod_sq_pkg::phase_0;  // loops until reset
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         phase <= mod_sq_pkg::idle;
         load  <= 1'b0;
         valid <= 1'b0;
      end else begin
         phase <= next_phase;
         valid <= (phase == mod_sq_pkg::phase_2);
         if (take_start) begin
            load <= 1'b1;
         end else if (phase == mod_sq_pkg::phase_2) begin
            load <= 1'b0;    // from now on the result feeds back
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take_start) begin
         sq_in_q <= sq_in;
      end
   end

   // operand must hold steady through phase_0 and phase_1
   assign operand = load ? sq_in_q : sq_out;

   // msb and lsb table passes both look at the same operand
   assert property (@(posedge clk) disable iff (reset)
      phase == mod_sq_pkg::phase_0 |=> $stable(operand))
      else $error("operand changed between the msb and lsb table passes");

endmodule

/* hw/square_grid.sv */
`timescale 1ns/100ps

module square_grid (
   input  mod_sq_pkg::operand_t operand,
   output mod_sq_pkg::grid_cv_t cv
);

   typedef logic [mod_sq_pkg::col_len-1:0] col_t;

   localparam int prod_len = 2 * mod_sq_pkg::bit_len;   // 34b product
   localparam int wl       = mod_sq_pkg::word_len;

   // 3:2 compression of one new term into a column pair, {carry, sum}
   function automatic logic [2*mod_sq_pkg::col_len-1:0] csa(input col_t c, input col_t s,
                                                            input col_t t);
      col_t maj;
      maj = (c & s) | (c & t) | (s & t);
      return {maj << 1, c ^ s ^ t};
   endfunction

   always_comb begin
      logic [prod_len-1:0] p;
      col_t                lo;
      col_t                hi;

      cv = '0;

      // upper triangle only, mirrored terms are doubled instead
      for (int i = 0; i < mod_sq_pkg::num_elements; i++) begin
         for (int j = i; j < mod_sq_pkg::num_elements; j++) begin
            p = operand[i] * operand[j];
            if (i == j) begin
               lo = col_t'(p[wl-1:0]);
               hi = col_t'(p[prod_len-1:wl]);
            end else begin
               lo = col_t'({p[wl-2:0], 1'b0});        // x2 shifts one bit up
               hi = col_t'(p[prod_len-1:wl-1]);
            end
            {cv.carry[i+j], cv.sum[i+j]}     = csa(cv.carry[i+j], cv.sum[i+j], lo);
            {cv.carry[i+j+1], cv.sum[i+j+1]} = csa(cv.carry[i+j+1], cv.sum[i+j+1], hi);
         end
      end
   end

endmodule

/* hw/column_partial_reduce.sv */
`timescale 1ns/100ps

module column_partial_reduce #(
   parameter int num_cols = mod_sq_pkg::grid_cols,
   parameter int in_len   = mod_sq_pkg::col_len
) (
   input  mod_sq_pkg::grid_cv_t  cv,
   output mod_sq_pkg::grid_red_t reduced
);

   localparam int wl = mod_sq_pkg::word_len;

   // column totals stay well inside in_len bits
   logic [in_len-1:0] col_sum [num_cols];

   always_comb begin
      for (int k = 0; k < num_cols; k++) begin
         col_sum[k] = cv.carry[k] + cv.sum[k];
      end

      // keep 16 bits per column, the rest moves one column up
      reduced[0] = mod_sq_pkg::element_t'(col_sum[0][wl-1:0]);
      for (int k = 1; k < num_cols - 1; k++) begin
         reduced[k] = mod_sq_pkg::element_t'(col_sum[k][wl-1:0]) +
                      mod_sq_pkg::element_t'(col_sum[k-1][in_len-1:wl]);
      end

      // top column has nowhere to pass its carry
      reduced[num_cols-1] = col_sum[num_cols-1][mod_sq_pkg::bit_len-1:0] +
                            mod_sq_pkg::element_t'(col_sum[num_cols-2][in_len-1:wl]);
   end

endmodule

/* hw/reduction_table.sv */
`timescale 1ns/100ps

module reduction_table #(
   parameter logic [mod_sq_pkg::num_words*mod_sq_pkg::word_len-1:0] MODULUS =
      64'hffff_ffff_ffff_ffc5
) (
   input  logic                                               clk,
   input  mod_sq_pkg::phase_e                                 phase,
   input  mod_sq_pkg::element_t   [mod_sq_pkg::lut_cols-1:0] upper,
   output mod_sq_pkg::table_row_t [mod_sq_pkg::lut_cols-1:0] lsb_rows,
   output mod_sq_pkg::table_row_t [mod_sq_pkg::lut_cols-1:0] msb_rows
);

   localparam int mod_len     = mod_sq_pkg::num_words * mod_sq_pkg::word_len;
   localparam int lut_entries = 2 ** mod_sq_pkg::lut_addr_len;
   localparam int half        = mod_sq_pkg::word_len / 2;   // lsb field width
   localparam int lut_cols    = mod_sq_pkg::lut_cols;

   typedef logic [mod_len-1:0]      residue_t;
   typedef residue_t [1:0]          entry_t;     // [0] lsb pass, [1] msb pass

   entry_t                                rom  [lut_cols][lut_entries];
   entry_t                                rd_q [lut_cols];
   logic [mod_sq_pkg::lut_addr_len-1:0]   addr [lut_cols];
   mod_sq_pkg::table_row_t [lut_cols-1:0] msb_hold;

   function automatic residue_t pow2_mod(input int e);
      logic [mod_len:0] v;
      v = 1;
      for (int i = 0; i < e; i++) begin
         v = v << 1;
         if (v >= MODULUS) begin
            v = v - MODULUS;
         end
      end
      return v[mod_len-1:0];
   endfunction

   function automatic residue_t mul_mod(input residue_t a, input residue_t b);
      logic [2*mod_len-1:0] p;
      p = a * b;
      return residue_t'(p % MODULUS);
   endfunction

   // residue spread over 16-bit words, redundant words stay zero
   function automatic mod_sq_pkg::table_row_t split_words(input residue_t r);
      mod_sq_pkg::table_row_t row;
      row = '0;
      for (int k = 0; k < mod_sq_pkg::num_words; k++) begin
         row[k] = {1'b0, r[k*mod_sq_pkg::word_len +: mod_sq_pkg::word_len]};
      end
      return row;
   endfunction

   // entry a of rom c: a * 2^(16(c+4)) mod M, msb pass with a further 2^8
   initial begin
      residue_t base_lsb;
      residue_t base_msb;
      for (int c = 0; c < lut_cols; c++) begin
         base_lsb = pow2_mod(mod_sq_pkg::word_len * (c + mod_sq_pkg::num_words));
         base_msb = pow2_mod(mod_sq_pkg::word_len * (c + mod_sq_pkg::num_words) + half);
         for (int a = 0; a < lut_entries; a++) begin
            rom[c][a][0] = mul_mod(residue_t'(a), base_lsb);
            rom[c][a][1] = mul_mod(residue_t'(a), base_msb);
         end
      end
   end

   always_comb begin
      for (int c = 0; c < lut_cols; c++) begin
         if (phase == mod_sq_pkg::phase_0) begin
            addr[c] = upper[c][mod_sq_pkg::bit_len-1:half];   // 9b msb field
         end else begin
            addr[c] = {1'b0, upper[c][half-1:0]};
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int c = 0; c < lut_cols; c++) begin
         rd_q[c] <= rom[c][addr[c]];
      end
      if (phase == mod_sq_pkg::phase_1) begin   // msb lookup from phase_0
         for (int c = 0; c < lut_cols; c++) begin
            msb_hold[c] <= split_words(rd_q[c][1]);
         end
      end
   end

   always_comb begin
      for (int c = 0; c < lut_cols; c++) begin
         lsb_rows[c] = split_words(rd_q[c][0]);
      end
   end

   assign msb_rows = msb_hold;

   assert property (@(posedge clk) MODULUS[0] && (MODULUS > 1))
      else $error("reduction modulus must be odd and above 1");

endmodule

/* hw/reduction_accumulator.sv */
`timescale 1ns/100ps

module reduction_accumulator (
   input  logic                                               clk,
   input  mod_sq_pkg::phase_e                                 phase,
   input  mod_sq_pkg::element_t   [mod_sq_pkg::num_words-1:0] low_cols,
   input  mod_sq_pkg::table_row_t [mod_sq_pkg::lut_cols-1:0]  lsb_rows,
   input  mod_sq_pkg::table_row_t [mod_sq_pkg::lut_cols-1:0]  msb_rows,
   output mod_sq_pkg::operand_t                               sq_out
);

   typedef logic [mod_sq_pkg::acc_len-1:0] acc_t;

   localparam int wl   = mod_sq_pkg::word_len;
   localparam int al   = mod_sq_pkg::acc_len;
   localparam int last = mod_sq_pkg::num_elements - 1;

   mod_sq_pkg::element_t [mod_sq_pkg::num_words-1:0] low_q;   // lines up with lsb rows
   acc_t                                              acc [mod_sq_pkg::num_elements];
   mod_sq_pkg::operand_t                              reduced;

   always_ff @(posedge clk) begin
      low_q <= low_cols;
   end

   always_comb begin
      for (int k = 0; k < mod_sq_pkg::num_elements; k++) begin
         acc[k] = '0;
      end
      for (int k = 0; k < mod_sq_pkg::num_words; k++) begin
         acc[k] = acc_t'(low_q[k]);   // square below 2^64 needs no table
      end
      for (int k = 0; k < mod_sq_pkg::num_elements; k++) begin
         for (int c = 0; c < mod_sq_pkg::lut_cols; c++) begin
            acc[k] = acc[k] + acc_t'(lsb_rows[c][k]) + acc_t'(msb_rows[c][k]);
         end
      end

      // neighbour carry fold, same scheme as the grid
      reduced[0] = mod_sq_pkg::element_t'(acc[0][wl-1:0]);
      for (int k = 1; k < last; k++) begin
         reduced[k] = mod_sq_pkg::element_t'(acc[k][wl-1:0]) +
                      mod_sq_pkg::element_t'(acc[k-1][al-1:wl]);
      end
      reduced[last] = acc[last][mod_sq_pkg::bit_len-1:0] +
                      mod_sq_pkg::element_t'(acc[last-1][al-1:wl]);
   end

   always_ff @(posedge clk) begin
      if (phase == mod_sq_pkg::phase_2) begin
         sq_out <= reduced;
      end
   end

endmodule

/* hw/mod_square_top.sv */
`timescale 1ns/100ps

module mod_square_top #(
   parameter logic [mod_sq_pkg::num_words*mod_sq_pkg::word_len-1:0] MODULUS =
      64'hffff_ffff_ffff_ffc5
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  mod_sq_pkg::operand_t sq_in,
   output mod_sq_pkg::operand_t sq_out,
   output logic                 valid
);

   mod_sq_pkg::phase_e                                 phase;
   mod_sq_pkg::operand_t                               operand;
   mod_sq_pkg::grid_cv_t                               cv;
   mod_sq_pkg::grid_red_t                              reduced;
   mod_sq_pkg::table_row_t [mod_sq_pkg::lut_cols-1:0] lsb_rows;
   mod_sq_pkg::table_row_t [mod_sq_pkg::lut_cols-1:0] msb_rows;

   square_sequencer u_sequencer (
      .clk     (clk),
      .reset   (reset),
      .start   (start),
      .sq_in   (sq_in),
      .sq_out  (sq_out),     // loopback
      .phase   (phase),
      .operand (operand),
      .valid   (valid)
   );

   square_grid u_grid (
      .operand (operand),
      .cv      (cv)
   );

   column_partial_reduce #(
      .num_cols (mod_sq_pkg::grid_cols),
      .in_len   (mod_sq_pkg::col_len)
   ) u_grid_reduce (
      .cv      (cv),
      .reduced (reduced)
   );

   reduction_table #(
      .MODULUS (MODULUS)
   ) u_table (
      .clk      (clk),
      .phase    (phase),
      .upper    (reduced[mod_sq_pkg::grid_cols-1:mod_sq_pkg::num_words]),
      .lsb_rows (lsb_rows),
      .msb_rows (msb_rows)
   );

   reduction_accumulator u_accumulator (
      .clk      (clk),
      .phase    (phase),
      .low_cols (reduced[mod_sq_pkg::num_words-1:0]),
      .lsb_rows (lsb_rows),
      .msb_rows (msb_rows),
      .sq_out   (sq_out)
   );

endmodule

/* bench/mod_square_tests.svh */
`ifndef MOD_SQUARE_TESTS_SVH
`define MOD_SQUARE_TESTS_SVH

// reference model in plain wide arithmetic
function automatic logic [63:0] square_mod(input logic [63:0] a);
   logic [127:0] p;
   p = {64'd0, a} * {64'd0, a};
   p = p % {64'd0, test_modulus};
   return p[63:0];
endfunction

function automatic logic [63:0] fold_operand(input mod_sq_pkg::operand_t v);
   logic [127:0] acc;
   logic [127:0] term;
   acc = '0;
   for (int k = 0; k < mod_sq_pkg::num_elements; k++) begin
      term = '0;
      term[mod_sq_pkg::bit_len-1:0] = v[k];
      acc = acc + (term << (mod_sq_pkg::word_len * k));   // element k weighs 2^(16k)
   end
   acc = acc % {64'd0, test_modulus};
   return acc[63:0];
endfunction

function automatic mod_sq_pkg::operand_t to_operand(input logic [63:0] x);
   mod_sq_pkg::operand_t op;
   op = '0;   // redundant words start empty
   for (int k = 0; k < mod_sq_pkg::num_words; k++) begin
      op[k] = {1'b0, x[k*mod_sq_pkg::word_len +: mod_sq_pkg::word_len]};
   end
   return op;
endfunction

function automatic logic [63:0] random_below_modulus();
   return {$urandom, $urandom} % test_modulus;
endfunction

task automatic reset_dut();
   @(posedge clk);
   reset <= 1'b1;
   start <= 1'b0;
   repeat (reset_cycles) @(posedge clk);
   reset <= 1'b0;
endtask

task automatic apply_start(input logic [63:0] x);
   @(posedge clk);
   start <= 1'b1;
   sq_in <= to_operand(x);
   @(posedge clk);
   start <= 1'b0;
endtask

// returns at the falling edge inside the valid cycle
task automatic wait_for_valid(input int max_cycles, output bit seen);
   seen = 1'b0;
   for (int i = 0; i < max_cycles && !seen; i++) begin
      @(negedge clk);
      if (valid === 1'b1) seen = 1'b1;
   end
   if (!seen) begin
      other_errors++;
      $display("no valid pulse within %0d cycles, time %0t", max_cycles, $time);
   end
endtask

task automatic run_sequence(input logic [63:0] x, input int count);
   logic [63:0] expected;
   bit          seen;
   apply_start(x);
   expected = x;
   for (int n = 1; n <= count; n++) begin
      wait_for_valid((n == 1) ? first_valid_limit : valid_gap, seen);
      if (!seen) return;
      expected = square_mod(expected);   // x^(2^n)
      check_operand($sformatf("sq_out[%0d]", n), sq_out, expected);
   end
endtask

task automatic test_idle_after_reset();
   reset_dut();
   repeat (idle_cycles) begin
      @(negedge clk);
      check_valid(1'b0, valid);
   end
endtask

task automatic test_square_of_two();
   bit seen;
   reset_dut();
   apply_start(64'd2);
   wait_for_valid(first_valid_limit, seen);
   if (seen) check_operand("sq_out", sq_out, 64'd4);
endtask

task automatic test_random_sequence();
   reset_dut();
   run_sequence(random_below_modulus(), iter_count);
endtask

task automatic test_valid_spacing();
   bit seen;
   reset_dut();
   apply_start(random_below_modulus());
   wait_for_valid(first_valid_limit, seen);
   if (!seen) return;
   repeat (spacing_count) begin
      @(negedge clk);
      check_valid(1'b0, valid);   // pulse is one cycle wide
      @(negedge clk);
      check_valid(1'b0, valid);
      @(negedge clk);
      check_valid(1'b1, valid);
   end
endtask

task automatic test_start_ignored();
   logic [63:0] x;
   logic [63:0] other;
   logic [63:0] expected;
   bit          seen;
   x     = random_below_modulus();
   other = random_below_modulus();
   if (other == x) other = x ^ 64'd1;
   reset_dut();
   apply_start(x);
   expected = x;
   for (int n = 1; n <= iter_count; n++) begin
      wait_for_valid((n == 1) ? first_valid_limit : valid_gap, seen);
      if (!seen) return;
      expected = square_mod(expected);
      check_operand($sformatf("sq_out[%0d]", n), sq_out, expected);
      if (n == 1) begin
         @(posedge clk);
         start <= 1'b1;   // loop is busy so this start must be dropped
         sq_in <= to_operand(other);
      end else if (n == 2) begin
         @(posedge clk);
         start <= 1'b0;   // start was high in all three phases
      end
   end
endtask

task automatic test_reset_mid_run();
   bit seen;
   reset_dut();
   apply_start(random_below_modulus());
   wait_for_valid(first_valid_limit, seen);
   if (seen) wait_for_valid(valid_gap, seen);
   reset_dut();
   repeat (idle_cycles) begin
      @(negedge clk);
      check_valid(1'b0, valid);
   end
   apply_start(test_modulus - 64'd1);
   wait_for_valid(first_valid_limit, seen);
   if (seen) check_operand("sq_out", sq_out, 64'd1);   // (-1)^2
endtask

`endif

/* bench/mod_square_tb.sv */
`timescale 1ns/100ps

module mod_square_tb;

   localparam logic [63:0] test_modulus = 64'hd1b5_4e2f_9a37_c86b;   // odd and full 64 bits
   localparam int unsigned seed         = 10460;
   localparam int clk_period            = 10;
   localparam int reset_cycles          = 8;
   localparam int idle_cycles           = 10;
   localparam int first_valid_limit     = 5;    // start to first valid
   localparam int valid_gap             = 3;    // one iteration
   localparam int iter_count            = 8;
   localparam int spacing_count         = 6;

   // rough length of all six tests plus slack
   localparam int test_cycles = 7 * (reset_cycles + 1) + 2 * idle_cycles +
                                6 * first_valid_limit +
                                valid_gap * (2 * iter_count + spacing_count) + 12;
   localparam int watchdog_cycles = test_cycles + 50;

   logic                 clk;
   logic                 reset;
   logic                 start;
   mod_sq_pkg::operand_t sq_in;
   mod_sq_pkg::operand_t sq_out;
   logic                 valid;

   int value_errors = 0;
   int valid_errors = 0;
   int other_errors = 0;

   mod_square_top #(
      .MODULUS (test_modulus)
   ) DUT (
      .clk    (clk),
      .reset  (reset),
      .start  (start),
      .sq_in  (sq_in),
      .sq_out (sq_out),
      .valid  (valid)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // redundant form is not unique so the result is compared as V mod M
   task automatic check_operand(input string name, input mod_sq_pkg::operand_t actual,
                                input logic [63:0] expected);
      logic [63:0] folded;
      folded = fold_operand(actual);
      if (folded !== expected) begin
         value_errors++;
         $display("ERR %0t %s expected %h actual %h", $time, name, expected, folded);
      end
   endtask

   task automatic check_valid(input logic expected, input logic actual);
      if (actual !== expected) begin
         valid_errors++;
         $display("ERR %0t valid expected %b actual %b", $time, expected, actual);
      end
   endtask

   `include "mod_square_tests.svh"

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, the tests did not complete",
               watchdog_cycles);
      $display("Finished with errors");
      $finish;
   end

   initial begin
      reset = 1'b1;
      start = 1'b0;
      sq_in = '0;
      void'($urandom(seed));

      test_idle_after_reset();
      test_square_of_two();
      test_random_sequence();
      test_valid_spacing();
      test_start_ignored();
      test_reset_mid_run();

      $display("errors: value %0d, valid %0d, other %0d",
               value_errors, valid_errors, other_errors);
      if (value_errors + valid_errors + other_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+bench
hw/mod_sq_pkg.sv
hw/square_sequencer.sv
hw/square_grid.sv
hw/column_partial_reduce.sv
hw/reduction_table.sv
hw/reduction_accumulator.sv
hw/mod_square_top.sv
bench/mod_square_tb.sv

/* Bender.yml */
package:
  name: mod_square

sources:
  - hw/mod_sq_pkg.sv
  - hw/square_sequencer.sv
  - hw/square_grid.sv
  - hw/column_partial_reduce.sv
  - hw/reduction_table.sv
  - hw/reduction_accumulator.sv
  - hw/mod_square_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/mod_square_tb.sv
